//--- verilog/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// word address of the fetch pc
`define BP_ADDR_W 30

// every table has 2**BP_IDX_W entries
`define BP_IDX_W 6

`define BP_HIST_W 6

`define BP_RAS_DEPTH 8

`endif

//--- verilog/bp_types_pkg.sv
`include "bp_defines.svh"

package bp_types_pkg;

    typedef logic [`BP_ADDR_W-1:0] addr_t;
    typedef logic [`BP_IDX_W-1:0] idx_t;
    // newest outcome in bit 0
    typedef logic [`BP_HIST_W-1:0] hist_t;
    typedef logic [$clog2(`BP_RAS_DEPTH)-1:0] ras_ptr_t;

    typedef enum logic [2:0] {
        kind_none     = 3'd0,
        kind_cond     = 3'd1,
        kind_jump     = 3'd2,
        kind_call     = 3'd3,
        kind_ret      = 3'd4,
        kind_indirect = 3'd5
    } kind_t;

    // xor of all index-wide slices of the address
    function automatic idx_t pc_fold(input addr_t pc);
        idx_t acc;
        acc = '0;
        for (int i = 0; i < `BP_ADDR_W / `BP_IDX_W; i++) begin
            acc = acc ^ pc[i*`BP_IDX_W +: `BP_IDX_W];
        end
        return acc;
    endfunction

    function automatic idx_t hist_fold(input addr_t pc, input hist_t hist);
        return pc_fold(pc) ^ hist;
    endfunction

endpackage

//--- verilog/bp_if_pkg.sv
package bp_if_pkg;

    import bp_types_pkg::*;

    // speculative state at the time of the prediction
    typedef struct packed {
        hist_t    gh;
        hist_t    bh;
        ras_ptr_t ras_top;
        logic     use_global;
    } pred_snap_t;

    typedef struct packed {
        addr_t      npc;
        kind_t      kind;
        logic       taken;
        pred_snap_t snap;
    } pred_resp_t;

    // one resolved branch from execute
    typedef struct packed {
        addr_t      pc;
        addr_t      npc;
        kind_t      kind;
        logic       taken;
        logic       mis_dir;
        logic       mis_npc;
        pred_snap_t snap;
    } resolve_t;

endpackage

//--- verilog/kind_table.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module kind_table (
    input  logic                clk,
    input  logic                rstn,
    input  bp_types_pkg::idx_t  rd_idx,
    output bp_types_pkg::kind_t kind,
    input  logic                wr_en,
    input  bp_types_pkg::idx_t  wr_idx,
    input  bp_types_pkg::kind_t wr_kind
);

    import bp_types_pkg::*;

    localparam int ENTRIES = 1 << `BP_IDX_W;

    kind_t kinds [ENTRIES];

    // lookup is combinational for the same-cycle prediction
    assign kind = kinds[rd_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                kinds[i] <= kind_none;
            end
        end else if (wr_en) begin
            // last resolved kind wins
            kinds[wr_idx] <= wr_kind;
        end
    end

endmodule

//--- verilog/local_hist_table.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module local_hist_table (
    input  logic                clk,
    input  logic                rstn,
    input  bp_types_pkg::idx_t  rd_idx,
    output bp_types_pkg::hist_t bh,
    input  logic                wr_en,
    input  bp_types_pkg::idx_t  wr_idx,
    input  logic                wr_taken
);

    import bp_types_pkg::*;

    localparam int ENTRIES = 1 << `BP_IDX_W;

    hist_t hists [ENTRIES];

    assign bh = hists[rd_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                hists[i] <= '0;
            end
        end else if (wr_en) begin
            // oldest outcome drops off the top
            hists[wr_idx] <= {hists[wr_idx][`BP_HIST_W-2:0], wr_taken};
        end
    end

endmodule

//--- verilog/dir_predictor.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module dir_predictor (
    input  logic               clk,
    input  logic               rstn,
    input  bp_types_pkg::idx_t g_idx,
    input  bp_types_pkg::idx_t l_idx,
    output logic               taken,
    output logic               use_global,
    input  logic               upd_en,
    input  bp_types_pkg::idx_t upd_g_idx,
    input  bp_types_pkg::idx_t upd_l_idx,
    input  logic               upd_taken,
    input  logic               upd_global_right,
    input  logic               upd_local_right
);

    import bp_types_pkg::*;

    localparam int ENTRIES = 1 << `BP_IDX_W;

    logic [1:0] g_ctr [ENTRIES];
    logic [1:0] l_ctr [ENTRIES];
    // chooser msb set selects the global component
    logic [1:0] c_ctr [ENTRIES];

    idx_t chooser_idx;

    function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && ctr != 2'd3) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'd0) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    // chooser shares the global index
    assign chooser_idx = g_idx;
    assign use_global = c_ctr[chooser_idx][1];
    assign taken = use_global ? g_ctr[g_idx][1] : l_ctr[l_idx][1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                g_ctr[i] <= 2'd1;
                l_ctr[i] <= 2'd1;
                c_ctr[i] <= 2'd1;
            end
        end else if (upd_en) begin
            g_ctr[upd_g_idx] <= ctr_next(g_ctr[upd_g_idx], upd_taken);
            l_ctr[upd_l_idx] <= ctr_next(l_ctr[upd_l_idx], upd_taken);
            // chooser only learns when the components disagree
            if (upd_global_right != upd_local_right) begin
                c_ctr[upd_g_idx] <= ctr_next(c_ctr[upd_g_idx], upd_global_right);
            end
        end
    end

endmodule

//--- verilog/global_hist.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module global_hist (
    input  logic                clk,
    input  logic                rstn,
    input  logic                shift_en,
    input  logic                shift_taken,
    input  logic                repair_en,
    input  bp_types_pkg::hist_t repair_gh,
    output bp_types_pkg::hist_t gh
);

    import bp_types_pkg::*;

    hist_t gh_next;

    // a repair overrides any speculative shift in the same cycle
    always_comb begin
        gh_next = gh;
        if (repair_en) begin
            gh_next = repair_gh;
        end else if (shift_en) begin
            gh_next = {gh[`BP_HIST_W-2:0], shift_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else begin
            gh <= gh_next;
        end
    end

endmodule

//--- verilog/target_predictor.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module target_predictor (
    input  logic                   clk,
    input  logic                   rstn,
    input  bp_types_pkg::addr_t    pc,
    input  bp_types_pkg::kind_t    kind,
    input  logic                   fire,
    output bp_types_pkg::addr_t    npc,
    output bp_types_pkg::ras_ptr_t ras_top,
    input  logic                   btb_wr_en,
    input  bp_types_pkg::idx_t     btb_wr_idx,
    input  bp_types_pkg::addr_t    btb_wr_target,
    input  logic                   repair_en,
    input  bp_types_pkg::ras_ptr_t repair_top,
    input  bp_types_pkg::kind_t    repair_kind,
    input  bp_types_pkg::addr_t    repair_pc
);

    import bp_types_pkg::*;

    localparam int ENTRIES = 1 << `BP_IDX_W;

    addr_t btb [ENTRIES];
    // circular, the oldest return is overwritten on overflow
    addr_t ras [`BP_RAS_DEPTH];

    ras_ptr_t ptr;
    ras_ptr_t ptr_next;
    logic     ras_wr_en;
    ras_ptr_t ras_wr_idx;
    addr_t    ras_wr_data;

    assign ras_top = ptr;

    always_comb begin
        case (kind)
            kind_ret:                                   npc = ras[ptr];
            kind_cond, kind_jump, kind_call, kind_indirect: npc = btb[pc_fold(pc)];
            default:                                    npc = pc + addr_t'(1);
        endcase
    end

    // repair replays the resolved call or ret on the snapshot pointer
    always_comb begin
        ptr_next = ptr;
        ras_wr_en = 1'b0;
        ras_wr_idx = repair_top + ras_ptr_t'(1);
        ras_wr_data = repair_pc + addr_t'(1);
        if (repair_en) begin
            ptr_next = repair_top;
            if (repair_kind == kind_call) begin
                ptr_next = repair_top + ras_ptr_t'(1);
                ras_wr_en = 1'b1;
            end else if (repair_kind == kind_ret) begin
                ptr_next = repair_top - ras_ptr_t'(1);
            end
        end else if (fire && kind == kind_call) begin
            ptr_next = ptr + ras_ptr_t'(1);
            ras_wr_en = 1'b1;
            ras_wr_idx = ptr + ras_ptr_t'(1);
            ras_wr_data = pc + addr_t'(1);
        end else if (fire && kind == kind_ret) begin
            ptr_next = ptr - ras_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ras_wr_en) begin
            ras[ras_wr_idx] <= ras_wr_data;
        end
        if (btb_wr_en) begin
            btb[btb_wr_idx] <= btb_wr_target;
        end
    end

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  bp_types_pkg::addr_t    req_pc,
    output logic                   req_ready,
    output logic                   resp_valid,
    output bp_if_pkg::pred_resp_t  resp,
    input  logic                   resp_ready,
    input  logic                   res_valid,
    input  bp_if_pkg::resolve_t    res
);

    import bp_types_pkg::*;
    import bp_if_pkg::*;

    logic     fire;
    kind_t    kind;
    kind_t    tgt_kind;
    hist_t    gh;
    hist_t    bh;
    logic     dir_taken;
    logic     use_global;
    logic     taken;
    addr_t    npc;
    ras_ptr_t ras_top;
    idx_t     pc_idx;
    idx_t     res_idx;
    idx_t     g_idx;
    idx_t     l_idx;
    idx_t     upd_g_idx;
    idx_t     upd_l_idx;
    logic     res_branch;
    logic     global_right;
    hist_t    repair_gh;

    assign req_ready = resp_ready;
    assign resp_valid = req_valid;
    assign fire = req_valid && resp_ready;

    assign pc_idx = pc_fold(req_pc);
    assign g_idx = hist_fold(req_pc, gh);
    assign l_idx = hist_fold(req_pc, bh);

    assign res_idx = pc_fold(res.pc);
    assign upd_g_idx = hist_fold(res.pc, res.snap.gh);
    assign upd_l_idx = hist_fold(res.pc, res.snap.bh);
    assign res_branch = res_valid && (res.kind != kind_none);

    always_comb begin
        case (kind)
            kind_none: taken = 1'b0;
            kind_cond: taken = dir_taken;
            default:   taken = 1'b1;
        endcase
    end

    // a not-taken branch falls through to pc+1 without touching the ras
    assign tgt_kind = taken ? kind : kind_none;

    always_comb begin
        resp.npc = npc;
        resp.kind = kind;
        resp.taken = taken;
        resp.snap.gh = gh;
        resp.snap.bh = bh;
        resp.snap.ras_top = ras_top;
        resp.snap.use_global = use_global;
    end

    // the unused component is taken to have predicted the opposite
    assign global_right = res.snap.use_global ? !res.mis_dir : res.mis_dir;
    assign repair_gh = {res.snap.gh[`BP_HIST_W-2:0], res.taken};

    kind_table kind_table_i (
        .clk     (clk),
        .rstn    (rstn),
        .rd_idx  (pc_idx),
        .kind    (kind),
        .wr_en   (res_valid),
        .wr_idx  (res_idx),
        .wr_kind (res.kind)
    );

    local_hist_table local_hist_table_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_idx   (pc_idx),
        .bh       (bh),
        .wr_en    (res_branch),
        .wr_idx   (res_idx),
        .wr_taken (res.taken)
    );

    dir_predictor dir_predictor_i (
        .clk              (clk),
        .rstn             (rstn),
        .g_idx            (g_idx),
        .l_idx            (l_idx),
        .taken            (dir_taken),
        .use_global       (use_global),
        .upd_en           (res_branch),
        .upd_g_idx        (upd_g_idx),
        .upd_l_idx        (upd_l_idx),
        .upd_taken        (res.taken),
        .upd_global_right (global_right),
        .upd_local_right  (!global_right)
    );

    global_hist global_hist_i (
        .clk         (clk),
        .rstn        (rstn),
        .shift_en    (fire && kind != kind_none),
        .shift_taken (taken),
        .repair_en   (res_valid && res.mis_dir),
        .repair_gh   (repair_gh),
        .gh          (gh)
    );

    // returns are never stored in the btb
    target_predictor target_predictor_i (
        .clk           (clk),
        .rstn          (rstn),
        .pc            (req_pc),
        .kind          (tgt_kind),
        .fire          (fire),
        .npc           (npc),
        .ras_top       (ras_top),
        .btb_wr_en     (res_branch && res.taken && res.kind != kind_ret),
        .btb_wr_idx    (res_idx),
        .btb_wr_target (res.npc),
        .repair_en     (res_valid && (res.mis_npc || res.mis_dir)),
        .repair_top    (res.snap.ras_top),
        .repair_kind   (res.kind),
        .repair_pc     (res.pc)
    );

endmodule

//--- tb/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb;

    import bp_types_pkg::*;
    import bp_if_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int ROUND_LIMIT = 16;

    logic       clk = 1'b0;
    logic       rstn;
    logic       req_valid;
    addr_t      req_pc;
    logic       req_ready;
    logic       resp_valid;
    pred_resp_t resp;
    logic       resp_ready;
    logic       res_valid;
    resolve_t   res;

    int          checks = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    logic [31:0] rng = 32'h1f9b_1abf;
    idx_t        used_folds[$];
    pred_resp_t  got;

    always #20 clk = ~clk;

    branch_predictor branch_predictor_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_pc     (req_pc),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .res_valid  (res_valid),
        .res        (res)
    );

    // valid and ready pass straight through
    handshake_follows: assert property (@(negedge clk)
        (resp_valid == req_valid) && (req_ready == resp_ready))
    else begin
        errors++;
        $display("mismatch at %0t: handshake outputs do not follow their inputs", $time);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // five 6-bit slices of the word address
    function automatic idx_t fold_addr(input addr_t a);
        return a[5:0] ^ a[11:6] ^ a[17:12] ^ a[23:18] ^ a[29:24];
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift(rng);
        v = rng;
    endtask

    // random pc whose fold is not used yet
    task automatic pick_pc(output addr_t pc);
        logic [31:0] r;
        logic        clash;
        logic        found;
        int          tries;
        pc = '0;
        found = 1'b0;
        tries = 0;
        while (!found && tries < 64) begin
            next_rand(r);
            clash = 1'b0;
            foreach (used_folds[i]) begin
                if (used_folds[i] == fold_addr(r[29:0])) begin
                    clash = 1'b1;
                end
            end
            if (!clash) begin
                pc = r[29:0];
                used_folds.push_back(fold_addr(pc));
                found = 1'b1;
            end
            tries++;
        end
    endtask

    task automatic check_value(input logic [63:0] got_v, input logic [63:0] exp_v,
                               input string what);
        checks++;
        assert (got_v === exp_v) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got_v, exp_v);
        end
    endtask

    // response is sampled on the falling edge
    task automatic request(input addr_t pc, input logic ready);
        int n;
        @(posedge clk);
        req_valid <= 1'b1;
        req_pc <= pc;
        resp_ready <= ready;
        n = 0;
        @(negedge clk);
        while (!resp_valid && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!resp_valid) begin
            errors++;
            $display("error: no response for pc %h within %0d cycles", pc, TIMEOUT);
        end
        got = resp;
    endtask

    task automatic resolve(input addr_t pc, input addr_t npc, input kind_t kind,
                           input logic taken, input logic mis_dir, input logic mis_npc,
                           input pred_snap_t snap);
        resolve_t r;
        r.pc = pc;
        r.npc = npc;
        r.kind = kind;
        r.taken = taken;
        r.mis_dir = mis_dir;
        r.mis_npc = mis_npc;
        r.snap = snap;
        @(posedge clk);
        req_valid <= 1'b0;
        resp_ready <= 1'b0;
        res_valid <= 1'b1;
        res <= r;
        @(posedge clk);
        res_valid <= 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("%-16s %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        addr_t       pc;
        addr_t       pc_a;
        addr_t       tgt_a;
        addr_t       pc_b;
        addr_t       tgt_b;
        addr_t       pc_c;
        addr_t       tgt_d;
        addr_t       pc_r;
        addr_t       pc_e;
        logic [31:0] r;
        pred_resp_t  first;
        pred_snap_t  call_snap;
        pred_snap_t  snap;
        int          rounds;
        logic        t;

        rstn <= 1'b0;
        req_valid <= 1'b0;
        req_pc <= '0;
        resp_ready <= 1'b0;
        res_valid <= 1'b0;
        res <= '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < 8; i++) begin
            pick_pc(pc);
            request(pc, 1'b0);
            check_value(64'(got.kind), 64'(kind_none), "kind after reset");
            check_value(64'(got.taken), 64'(1'b0), "taken after reset");
            check_value(64'(got.npc), 64'(pc + addr_t'(1)), "npc after reset");
            check_value(64'(got.snap), 64'(0), "snapshot after reset");
        end
        end_test("reset default");

        pick_pc(pc_a);
        next_rand(r);
        tgt_a = r[29:0];
        resolve(pc_a, tgt_a, kind_jump, 1'b1, 1'b0, 1'b0, '0);
        request(pc_a, 1'b0);
        check_value(64'(got.kind), 64'(kind_jump), "kind of learned jump");
        check_value(64'(got.taken), 64'(1'b1), "taken of learned jump");
        check_value(64'(got.npc), 64'(tgt_a), "npc of learned jump");
        end_test("jump learning");

        // train with the snapshot of each prediction until the direction flips
        pick_pc(pc_b);
        next_rand(r);
        tgt_b = r[29:0];
        request(pc_b, 1'b0);
        rounds = 0;
        while (!got.taken && rounds < ROUND_LIMIT) begin
            resolve(pc_b, tgt_b, kind_cond, 1'b1, 1'b1, got.npc != tgt_b, got.snap);
            request(pc_b, 1'b0);
            rounds++;
        end
        check_value(64'(got.taken), 64'(1'b1), "taken after taken resolutions");
        check_value(64'(got.kind), 64'(kind_cond), "kind of trained branch");
        check_value(64'(got.npc), 64'(tgt_b), "npc of taken branch");
        rounds = 0;
        while (got.taken && rounds < ROUND_LIMIT) begin
            resolve(pc_b, pc_b + addr_t'(1), kind_cond, 1'b0, 1'b1,
                    got.npc != pc_b + addr_t'(1), got.snap);
            request(pc_b, 1'b0);
            rounds++;
        end
        check_value(64'(got.taken), 64'(1'b0), "taken after not-taken resolutions");
        check_value(64'(got.npc), 64'(pc_b + addr_t'(1)), "npc of not-taken branch");
        end_test("cond training");

        pick_pc(pc_c);
        pick_pc(pc_r);
        next_rand(r);
        tgt_d = r[29:0];
        resolve(pc_c, tgt_d, kind_call, 1'b1, 1'b0, 1'b0, '0);
        resolve(pc_r, pc_c + addr_t'(1), kind_ret, 1'b1, 1'b0, 1'b0, '0);
        request(pc_c, 1'b1);
        check_value(64'(got.kind), 64'(kind_call), "kind of call");
        check_value(64'(got.npc), 64'(tgt_d), "npc of call");
        call_snap = got.snap;
        request(pc_r, 1'b1);
        check_value(64'(got.kind), 64'(kind_ret), "kind of ret");
        check_value(64'(got.npc), 64'(pc_c + addr_t'(1)), "npc of matched ret");
        // unmatched ret pops past the call
        request(pc_r, 1'b1);
        resolve(pc_c, tgt_d, kind_call, 1'b1, 1'b0, 1'b1, call_snap);
        request(pc_r, 1'b0);
        check_value(64'(got.npc), 64'(pc_c + addr_t'(1)), "npc of ret after repair");
        check_value(64'(got.snap.ras_top), 64'(ras_ptr_t'(call_snap.ras_top + 3'd1)),
                    "ras top after repair");
        end_test("call and return");

        request(pc_a, 1'b0);
        first = got;
        check_value(64'(got.kind), 64'(kind_jump), "kind under back-pressure");
        check_value(64'(got.npc), 64'(tgt_a), "npc under back-pressure");
        for (int i = 0; i < 3; i++) begin
            request(pc_a, 1'b0);
            check_value(64'(got), 64'(first), "repeated response under back-pressure");
        end
        request(pc_a, 1'b1);
        request(pc_a, 1'b0);
        check_value(64'(got.snap.gh), 64'({first.snap.gh[4:0], 1'b1}), "gh after one fire");
        end_test("back-pressure");

        pick_pc(pc_e);
        for (int i = 0; i < 2; i++) begin
            next_rand(r);
            snap = '0;
            snap.gh = r[5:0];
            t = r[8];
            resolve(pc_e, pc_e + addr_t'(1), kind_cond, t, 1'b1, 1'b0, snap);
            request(pc_e, 1'b0);
            check_value(64'(got.snap.gh), 64'({snap.gh[4:0], t}), "gh after repair");
        end
        end_test("history repair");

        @(posedge clk);
        req_valid <= 1'b0;
        resp_ready <= 1'b0;
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- branch_pred.f
+incdir+verilog
verilog/bp_types_pkg.sv
verilog/bp_if_pkg.sv
verilog/kind_table.sv
verilog/local_hist_table.sv
verilog/dir_predictor.sv
verilog/global_hist.sv
verilog/target_predictor.sv
verilog/branch_predictor.sv
tb/branch_predictor_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f branch_pred.f \
    --top-module branch_predictor_tb \
    -o branch_predictor_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/branch_predictor_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1
